// File: dv/cr16_chk.sv
// strobe assertions for the decoder FSM, bound into every control_and_decoder instance
`timescale 1ns/1ps
`include "cr16_consts.svh"

module cr16_chk (
    input logic                   clk,
    input logic                   reset,
    input logic                   ir_en,
    input logic                   pc_en,
    input logic                   reg_we,
    input logic                   psr_we,
    input logic [`CR16_NREGS-1:0] reg_en,
    input logic [`CR16_XLEN-1:0]  ir_word    // raw instruction register
);

    logic [3:0] ir_op;  // opcode straight from the word

    assign ir_op = (ir_word[15:12] == 4'h0) ? ir_word[7:4] : ir_word[15:12];

    // all quiet while reset is held
    a_quiet_in_reset: assert property (@(posedge clk)
        !reset |-> !(ir_en || pc_en || reg_we || psr_we))
        else $error("strobe high while reset is asserted");

    // single cycle pulses
    a_ir_pulse: assert property (@(posedge clk) disable iff (!reset)
        ir_en |=> !ir_en ##1 !ir_en)   // next load at least 3 cycles later
        else $error("ir_en not a one cycle pulse spaced 3 apart");

    a_decode_to_exec: assert property (@(posedge clk) disable iff (!reset)
        ir_en |=> pc_en)
        else $error("execute did not follow decode");

    a_pc_pulse: assert property (@(posedge clk) disable iff (!reset)
        pc_en |=> !pc_en && !ir_en)    // back to fetch
        else $error("pc_en held or decode right after execute");

    a_we_pulse: assert property (@(posedge clk) disable iff (!reset)
        reg_we |=> !reg_we)
        else $error("reg_we held longer than one cycle");

    // cmp, nop and the spare codes never write
    a_no_write_cmp_nop: assert property (@(posedge clk) disable iff (!reset)
        reg_we |-> (ir_op != `CR16_OP_CMP) && (ir_op != `CR16_OP_NOP) &&
                   (ir_op != 4'hE) && (ir_op != 4'hF))
        else $error("register write on cmp or nop");

    // write select must hit the destination field of the word
    a_onehot_en: assert property (@(posedge clk) disable iff (!reset)
        reg_we |-> $onehot(reg_en) && reg_en[ir_word[11:8]])
        else $error("reg_en not one-hot on the destination during a write");

endmodule

bind control_and_decoder cr16_chk u_chk (
    .clk     (clk),
    .reset   (reset),
    .ir_en   (ir_en),
    .pc_en   (pc_en),
    .reg_we  (reg_we),
    .psr_we  (psr_we),
    .reg_en  (reg_en),
    .ir_word (ir)
);

// File: dv/cr16_monitor.sv
// retire checker: shadow memory, registers and flags, a reference model and the per-test result lines
`timescale 1ns/1ps
`include "cr16_consts.svh"

module cr16_monitor (
    input logic                   clk,
    input logic                   reset,
    input logic                   imem_we,     // snooped program load
    input logic [`CR16_PC_W-1:0]  imem_addr,
    input logic [`CR16_XLEN-1:0]  imem_wdata,
    input cr16_pkg::cr16_retire_t retire
);

    logic [`CR16_XLEN-1:0] shadow_mem  [`CR16_IMEM_DEPTH];
    logic [`CR16_XLEN-1:0] shadow_regs [`CR16_NREGS];
    logic [`CR16_PC_W-1:0] shadow_pc;
    cr16_pkg::cr16_psr_t   shadow_psr;

    string test_name    = "idle";
    int    test_errors  = 0;
    int    test_retires = 0;
    int    error_count  = 0;   // all tests
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    checked      = 0;

    // expected retire record straight from the operation rules
    function automatic cr16_pkg::cr16_retire_t ref_exec(input logic [15:0] word,
                                                        input logic [`CR16_PC_W-1:0] at_pc);
        cr16_pkg::cr16_retire_t e;
        logic [3:0]  op;
        logic [3:0]  rd;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] res;
        logic        writes;
        int          cin;
        int          u;     // unsigned sum or difference
        int          s;     // signed sum or difference
        int          sh;
        e        = '0;
        e.valid  = 1'b1;
        e.pc     = at_pc;
        e.psr    = shadow_psr;
        rd       = word[11:8];  // same place in both forms
        if (word[15:12] == 4'h0) begin
            op = word[7:4];
            b  = shadow_regs[word[3:0]];
        end else begin
            op = word[15:12];
            b  = {{8{word[7]}}, word[7:0]};
        end
        a      = shadow_regs[rd];
        writes = 1'b1;
        res    = '0;
        cin    = ((op == `CR16_OP_ADDC) || (op == `CR16_OP_SUBC)) ? int'(shadow_psr.c) : 0;
        case (op)
            `CR16_OP_ADD, `CR16_OP_ADDC, `CR16_OP_ADDU: begin
                u   = int'(a) + int'(b) + cin;
                s   = int'($signed(a)) + int'($signed(b)) + cin;
                res = u[15:0];
                if (op != `CR16_OP_ADDU) begin
                    e.psr.c = (u > 65535);
                    e.psr.f = (s > 32767) || (s < -32768);
                end
            end
            `CR16_OP_SUB, `CR16_OP_SUBC: begin
                u       = int'(a) - int'(b) - cin;
                s       = int'($signed(a)) - int'($signed(b)) - cin;
                res     = u[15:0];
                e.psr.c = (u < 0);   // borrow
                e.psr.f = (s > 32767) || (s < -32768);
            end
            `CR16_OP_CMP: begin
                writes  = 1'b0;
                e.psr.z = (a == b);
                e.psr.l = (int'(a) < int'(b));
                e.psr.n = (int'($signed(a)) < int'($signed(b)));
            end
            `CR16_OP_AND: res = a & b;
            `CR16_OP_OR:  res = a | b;
            `CR16_OP_XOR: res = a ^ b;
            `CR16_OP_MOV: res = b;
            `CR16_OP_NOT: res = ~b;
            `CR16_OP_LSH, `CR16_OP_ASHU: begin
                sh = int'($signed(b[4:0]));   // -16..15
                if (sh >= 0) begin
                    res = a << sh;
                end else if (op == `CR16_OP_LSH) begin
                    res = a >> (-sh);
                end else begin
                    s   = int'($signed(a)) >>> (-sh);
                    res = s[15:0];
                end
            end
            default: writes = 1'b0;           // nop and the two spare codes
        endcase
        e.reg_we = writes;
        e.rdest  = rd;
        e.wdata  = writes ? res : '0;
        return e;
    endfunction

    task automatic compare_field(input string what, input logic [15:0] exp_v,
                                 input logic [15:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERROR %s %s: expected %h actual %h", test_name, what, exp_v, act_v);
            test_errors++;
            error_count++;
        end
    endtask

    task automatic check_retire();
        cr16_pkg::cr16_retire_t e;
        e = ref_exec(shadow_mem[shadow_pc], shadow_pc);
        compare_field("pc", 16'(e.pc), 16'(retire.pc));
        compare_field("reg_we", 16'(e.reg_we), 16'(retire.reg_we));
        compare_field("rdest", 16'(e.rdest), 16'(retire.rdest));
        if (e.reg_we) begin
            compare_field("wdata", e.wdata, retire.wdata);
            shadow_regs[e.rdest] = e.wdata;
        end
        compare_field("psr", 16'(e.psr), 16'(retire.psr));
        shadow_psr = e.psr;
        shadow_pc  = (shadow_pc == `CR16_PC_W'(`CR16_IMEM_DEPTH - 1)) ? '0 : shadow_pc + 1'b1;
        test_retires++;
        checked++;
    endtask

    // sampled mid-cycle, retire settled since the rising edge
    always @(negedge clk) begin
        if (!reset) begin
            for (int i = 0; i < `CR16_NREGS; i++) begin
                shadow_regs[i] = '0;
            end
            shadow_pc  = '0;
            shadow_psr = '0;
        end else begin
            if (imem_we) begin
                shadow_mem[imem_addr] = imem_wdata;
            end
            if (retire.valid) begin
                check_retire();
            end
        end
    end

    task automatic start_test(input string name);
        test_name    = name;
        test_errors  = 0;
        test_retires = 0;
    endtask

    task automatic finish_test(input int expected_retires);
        if (test_retires != expected_retires) begin
            $display("%s: saw %0d retirements but %0d were expected",
                     test_name, test_retires, expected_retires);
            test_errors++;
            error_count++;
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok, %0d retirements", test_name, test_retires);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", test_name, test_errors);
        end
    endtask

endmodule

// File: dv/cr16_tb.sv
// testbench top: clock, reset, program loading, the five directed and random tests and the watchdog
`timescale 1ns/1ps
`include "cr16_consts.svh"

module cr16_tb;

    localparam int RETIRES_TOTAL = 9 + 7 + 12 + 12 + 70;
    localparam int LOAD_CYCLES   = 5 * (`CR16_IMEM_DEPTH + 10);  // load, reset, idle per test
    localparam real TIMEOUT_NS   = (RETIRES_TOTAL * 3 + LOAD_CYCLES + 10) * 10.0 * 4;

    logic                   clk;
    logic                   reset;
    logic                   run;
    logic                   imem_we;
    logic [`CR16_PC_W-1:0]  imem_addr;
    logic [`CR16_XLEN-1:0]  imem_wdata;
    cr16_pkg::cr16_retire_t retire;

    logic [31:0]           lfsr_state = 32'h192d_eeee;
    logic [`CR16_XLEN-1:0] prog [$];

    cr16_core u_dut (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .retire     (retire)
    );

    cr16_monitor u_mon (
        .clk        (clk),
        .reset      (reset),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .retire     (retire)
    );

    always #5 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic next_random_bit();
        logic out;
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out;
    endfunction

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], next_random_bit()};
        end
        return v;
    endfunction

    // encoders for the two forms
    function automatic logic [15:0] rr(input logic [3:0] op, input logic [3:0] rd,
                                       input logic [3:0] rs);
        return {4'h0, rd, op, rs};
    endfunction

    function automatic logic [15:0] ri(input logic [3:0] op, input logic [3:0] rd,
                                       input logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    // whole memory written, nop fill past the program
    task automatic load_program();
        for (int i = 0; i < `CR16_IMEM_DEPTH; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= `CR16_PC_W'(i);
            imem_wdata <= (i < prog.size()) ? prog[i] : 16'h0000;
        end
        @(posedge clk);
        imem_we <= 1'b0;
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
    endtask

    task automatic run_test(input string name, input int n);
        int seen;
        seen = 0;
        u_mon.start_test(name);
        load_program();
        pulse_reset();
        run <= 1'b1;
        while (seen < n) begin
            @(negedge clk);
            if (retire.valid) begin
                seen++;
            end
        end
        @(posedge clk);
        run <= 1'b0;               // lands with the s2 edge, fsm parks in s0
        repeat (4) @(posedge clk);
        u_mon.finish_test(n);
        prog.delete();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish in the expected time");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [3:0] op;
        clk        = 1'b0;
        reset      = 1'b0;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_addr  = '0;
        imem_wdata = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b1;

        // register form arithmetic
        prog = '{ri(`CR16_OP_MOV, 1, 8'h35), ri(`CR16_OP_MOV, 2, 8'hF9),
                 ri(`CR16_OP_MOV, 3, 8'h7F), rr(`CR16_OP_ADD, 1, 2),
                 rr(`CR16_OP_ADDU, 3, 2), rr(`CR16_OP_SUB, 1, 3),
                 rr(`CR16_OP_AND, 2, 3), rr(`CR16_OP_OR, 4, 1), rr(`CR16_OP_XOR, 3, 1)};
        run_test("reg_arith", 9);

        // immediates, both signs
        prog = '{ri(`CR16_OP_ADD, 1, 8'hFF), ri(`CR16_OP_ADD, 2, 8'h40),
                 ri(`CR16_OP_SUB, 2, 8'h80), ri(`CR16_OP_AND, 1, 8'h0F),
                 ri(`CR16_OP_XOR, 3, 8'hAA), ri(`CR16_OP_OR, 4, 8'h81),
                 ri(`CR16_OP_MOV, 5, 8'h80)};
        run_test("imm_form", 7);

        // carry chain then compares
        prog = '{ri(`CR16_OP_MOV, 1, 8'h7F), ri(`CR16_OP_LSH, 1, 8'h08),
                 rr(`CR16_OP_ADD, 1, 1), ri(`CR16_OP_MOV, 2, 8'hFF),
                 rr(`CR16_OP_ADD, 2, 2), rr(`CR16_OP_ADDC, 1, 2),
                 rr(`CR16_OP_SUBC, 3, 2), rr(`CR16_OP_CMP, 1, 1),
                 ri(`CR16_OP_MOV, 4, 8'h01), ri(`CR16_OP_MOV, 5, 8'h02),
                 rr(`CR16_OP_CMP, 4, 5), rr(`CR16_OP_CMP, 4, 2)};
        run_test("carry_cmp", 12);

        // shifts on negative values, then not
        prog = '{ri(`CR16_OP_MOV, 1, 8'h81), ri(`CR16_OP_MOV, 2, 8'h81),
                 ri(`CR16_OP_MOV, 3, 8'h81), ri(`CR16_OP_MOV, 4, 8'h81),
                 ri(`CR16_OP_LSH, 1, 8'h03), ri(`CR16_OP_LSH, 2, 8'hFC),
                 ri(`CR16_OP_ASHU, 3, 8'hFC), ri(`CR16_OP_ASHU, 4, 8'h05),
                 ri(`CR16_OP_MOV, 5, 8'hF0), rr(`CR16_OP_ASHU, 3, 5),
                 rr(`CR16_OP_NOT, 6, 1), ri(`CR16_OP_NOT, 7, 8'h12)};
        run_test("shift_not", 12);

        // 48 random words, 70 retires so pc wraps past 63
        for (int i = 0; i < 48; i++) begin
            if (random_bits(1) == 16'd0) begin
                prog.push_back(rr(4'(random_bits(4)), 4'(random_bits(4)), 4'(random_bits(4))));
            end else begin
                op = 4'(random_bits(4));
                if (op == 4'h0) begin
                    op = `CR16_OP_MOV;   // zero would select register form
                end
                prog.push_back(ri(op, 4'(random_bits(4)), 8'(random_bits(8))));
            end
        end
        run_test("random_prog", 70);

        $display("tests %0d, failed %0d, retirements checked %0d, errors %0d",
                 u_mon.tests_run, u_mon.tests_failed, u_mon.checked, u_mon.error_count);
        if (u_mon.error_count == 0 && u_mon.tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: logic/alu.sv
// cr16 alu: operand select, fourteen operations, candidate flags and the psr register
`timescale 1ns/1ps
`include "cr16_consts.svh"

module alu (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        psr_we,    // s2 pulse
    input  cr16_pkg::cr16_ctrl_t        ctrl,
    input  logic [`CR16_XLEN-1:0]       a,         // rdest value
    input  logic [`CR16_XLEN-1:0]       b_reg,     // rsrc value
    output logic [`CR16_XLEN-1:0]       result,
    output cr16_pkg::cr16_psr_t         next_psr,  // flags after this op
    output cr16_pkg::cr16_psr_t         psr
);

    localparam int W = `CR16_XLEN;

    logic [W-1:0] b;
    logic         cin;
    logic [W:0]   sum;        // msb is carry out
    logic [W:0]   diff;       // msb is borrow
    logic         add_ovf;
    logic         sub_ovf;
    logic [4:0]   amt;        // signed shift count
    logic [4:0]   ramt;       // magnitude for right shifts, up to 16
    logic [W-1:0] shl;
    logic [W-1:0] lsr;
    logic [W-1:0] asr;

    assign b   = ctrl.imm_en ? ctrl.imm16 : b_reg;
    assign cin = ((ctrl.op == `CR16_OP_ADDC) || (ctrl.op == `CR16_OP_SUBC)) ? psr.c : 1'b0;

    assign sum     = {1'b0, a} + {1'b0, b} + {{W{1'b0}}, cin};
    assign diff    = {1'b0, a} - {1'b0, b} - {{W{1'b0}}, cin};
    assign add_ovf = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);   // like signs, sign flips
    assign sub_ovf = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);

    assign amt  = b[4:0];
    assign ramt = 5'd0 - amt;
    assign shl  = a << amt[3:0];
    assign lsr  = a >> ramt;               // 16 clears the word
    assign asr  = $signed(a) >>> ramt;     // 16 fills with the sign

    always_comb begin
        result   = '0;  // cmp and nop write nothing
        next_psr = psr; // untouched unless the op says so
        case (ctrl.op)
            `CR16_OP_ADD, `CR16_OP_ADDC: begin
                result     = sum[W-1:0];
                next_psr.c = sum[W];
                next_psr.f = add_ovf;
            end
            `CR16_OP_ADDU: result = sum[W-1:0];  // cin is 0 here
            `CR16_OP_SUB, `CR16_OP_SUBC: begin
                result     = diff[W-1:0];
                next_psr.c = diff[W];
                next_psr.f = sub_ovf;
            end
            `CR16_OP_CMP: begin
                next_psr.z = (a == b);
                next_psr.l = (a < b);
                next_psr.n = ($signed(a) < $signed(b));
            end
            `CR16_OP_AND:  result = a & b;
            `CR16_OP_OR:   result = a | b;
            `CR16_OP_XOR:  result = a ^ b;
            `CR16_OP_MOV:  result = b;
            `CR16_OP_NOT:  result = ~b;
            `CR16_OP_LSH:  result = amt[4] ? lsr : shl;  // negative count goes right
            `CR16_OP_ASHU: result = amt[4] ? asr : shl;
            default: ;                                   // nop
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            psr <= '0;
        end else if (psr_we) begin
            psr <= next_psr;
        end
    end

endmodule

// File: logic/control_and_decoder.sv
// three state fsm with the instruction register, format decode and the execute strobes
`timescale 1ns/1ps
`include "cr16_consts.svh"

module control_and_decoder (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        run,      // fsm holds in s0 while low
    input  cr16_pkg::cr16_instr_u       instr,    // memory word at pc
    output logic                        pc_en,    // pc step in s2
    output logic                        ir_en,    // ir load in s1
    output logic                        reg_we,   // regfile write in s2
    output logic                        psr_we,   // flag update in s2
    output logic [`CR16_NREGS-1:0]      reg_en,   // one-hot write select
    output cr16_pkg::cr16_ctrl_t        ctrl
);

    // states
    localparam logic [1:0] S0 = 2'd0;  // fetch
    localparam logic [1:0] S1 = 2'd1;  // decode
    localparam logic [1:0] S2 = 2'd2;  // execute + writeback

    logic [1:0]            state;
    logic [1:0]            next_state;
    cr16_pkg::cr16_instr_u ir;
    logic [3:0]            raw_op;     // opcode before the legality check
    logic                  op_writes;  // class bits from the decoded op
    logic                  op_flags;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= S0;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            S0:      next_state = run ? S1 : S0;
            S1:      next_state = S2;
            S2:      next_state = S0;  // back to fetch whatever run does
            default: next_state = S0;  // unused code
        endcase
    end

    // ir holds the word for s2
    always_ff @(posedge clk) begin
        if (ir_en) begin
            ir <= instr;
        end
    end

    // format split through the union views
    always_comb begin
        ctrl.rdest = ir.rr.rdest;  // bits 11:8 in both forms
        ctrl.rsrc  = ir.rr.rsrc;   // low imm bits in immediate form
        if (ir.rr.major == 4'd0) begin
            raw_op      = ir.rr.op;
            ctrl.imm_en = 1'b0;
        end else begin
            raw_op      = ir.ri.op;
            ctrl.imm_en = 1'b1;
        end
        ctrl.imm16 = {{(`CR16_XLEN-8){ir.ri.imm8[7]}}, ir.ri.imm8};  // sign extend
    end

    // the two spare codes fall to nop
    always_comb begin
        case (raw_op)
            `CR16_OP_ADD, `CR16_OP_ADDU, `CR16_OP_ADDC,
            `CR16_OP_SUB, `CR16_OP_SUBC, `CR16_OP_CMP,
            `CR16_OP_AND, `CR16_OP_OR,   `CR16_OP_XOR,
            `CR16_OP_MOV, `CR16_OP_LSH,  `CR16_OP_NOT,
            `CR16_OP_ASHU, `CR16_OP_NOP: ctrl.op = raw_op;
            default:                     ctrl.op = `CR16_OP_NOP;
        endcase
    end

    // cmp and nop leave the regfile alone
    assign op_writes = (ctrl.op != `CR16_OP_CMP) && (ctrl.op != `CR16_OP_NOP);
    // flag-neutral ops
    assign op_flags  = (ctrl.op != `CR16_OP_NOP) && (ctrl.op != `CR16_OP_MOV) &&
                       (ctrl.op != `CR16_OP_NOT);

    // strobes decoded from state only
    assign ir_en  = (state == S1);
    assign pc_en  = (state == S2);
    assign reg_we = (state == S2) && op_writes;
    assign psr_we = (state == S2) && op_flags;

    // one-hot rdest only while writing
    assign reg_en = reg_we ? (`CR16_NREGS'(1) << ctrl.rdest) : '0;

endmodule

// File: logic/cr16_consts.svh
// widths, memory depth and opcode codes for the cr16 core, included wherever they are needed
`ifndef CR16_CONSTS_SVH
`define CR16_CONSTS_SVH

// datapath
`define CR16_XLEN        16                         // data and instruction word
`define CR16_NREGS       16                         // general registers r0..r15
`define CR16_IMEM_DEPTH  64                         // instruction words, pc wraps here
`define CR16_PC_W        $clog2(`CR16_IMEM_DEPTH)   // 6 bits of pc

// opcode codes, same nibble in both formats
`define CR16_OP_NOP   4'b0000
`define CR16_OP_AND   4'b0001
`define CR16_OP_OR    4'b0010
`define CR16_OP_XOR   4'b0011
`define CR16_OP_LSH   4'b0100
`define CR16_OP_ADD   4'b0101
`define CR16_OP_ADDU  4'b0110
`define CR16_OP_ADDC  4'b0111
`define CR16_OP_NOT   4'b1000
`define CR16_OP_SUB   4'b1001
`define CR16_OP_SUBC  4'b1010
`define CR16_OP_CMP   4'b1011
`define CR16_OP_ASHU  4'b1100
`define CR16_OP_MOV   4'b1101
// 4'b1110 and 4'b1111 are unassigned, decoded as nop

`endif

// File: logic/cr16_core.sv
// top of the cr16 core: fetch, decode, regfile and alu wired up, plus the per-instruction retire trace
`timescale 1ns/1ps
`include "cr16_consts.svh"

module cr16_core (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        run,
    input  logic                        imem_we,
    input  logic [`CR16_PC_W-1:0]       imem_addr,
    input  logic [`CR16_XLEN-1:0]       imem_wdata,
    output cr16_pkg::cr16_retire_t      retire
);

    logic                    pc_en;
    logic                    reg_we;
    logic                    psr_we;
    logic [`CR16_NREGS-1:0]  reg_en;
    logic [`CR16_PC_W-1:0]   pc;
    cr16_pkg::cr16_instr_u   instr;
    cr16_pkg::cr16_ctrl_t    ctrl;
    logic [`CR16_XLEN-1:0]   rdata_a;
    logic [`CR16_XLEN-1:0]   rdata_b;
    logic [`CR16_XLEN-1:0]   result;
    cr16_pkg::cr16_psr_t     next_psr;
    cr16_pkg::cr16_psr_t     psr;

    fetch_unit u_fetch (
        .clk        (clk),
        .reset      (reset),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .pc_en      (pc_en),
        .pc         (pc),
        .instr      (instr)
    );

    control_and_decoder u_ctrl (
        .clk    (clk),
        .reset  (reset),
        .run    (run),
        .instr  (instr),
        .pc_en  (pc_en),
        .ir_en  (),          // ir load stays inside the decoder
        .reg_we (reg_we),
        .psr_we (psr_we),
        .reg_en (reg_en),
        .ctrl   (ctrl)
    );

    register_file u_regs (
        .clk     (clk),
        .reset   (reset),
        .reg_we  (reg_we),
        .reg_en  (reg_en),
        .wdata   (result),
        .raddr_a (ctrl.rdest),
        .raddr_b (ctrl.rsrc),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    alu u_alu (
        .clk      (clk),
        .reset    (reset),
        .psr_we   (psr_we),
        .ctrl     (ctrl),
        .a        (rdata_a),
        .b_reg    (rdata_b),
        .result   (result),
        .next_psr (next_psr),
        .psr      (psr)
    );

    // one record per s2, pc not yet stepped
    assign retire.valid  = pc_en;
    assign retire.pc     = pc;
    assign retire.reg_we = reg_we;
    assign retire.rdest  = ctrl.rdest;
    assign retire.wdata  = result;
    assign retire.psr    = psr_we ? next_psr : psr;  // value after the edge

endmodule

// File: logic/cr16_pkg.sv
// shared types of the cr16 core: instruction views, decoded control, flags and retire trace
`include "cr16_consts.svh"

package cr16_pkg;

    // register form, top nibble zero
    typedef struct packed {
        logic [3:0] major;  // 4'b0000 selects this view
        logic [3:0] rdest;
        logic [3:0] op;
        logic [3:0] rsrc;
    } cr16_rr_t;

    // immediate form, top nibble is the opcode
    typedef struct packed {
        logic [3:0] op;     // nonzero
        logic [3:0] rdest;
        logic [7:0] imm8;   // signed
    } cr16_ri_t;

    // one fetched word, two ways to read it
    typedef union packed {
        cr16_rr_t rr;
        cr16_ri_t ri;
    } cr16_instr_u;

    typedef struct packed {
        logic [3:0]            op;     // legal opcode, unknown codes become nop
        logic [3:0]            rdest;  // also operand a
        logic [3:0]            rsrc;   // operand b in register form
        logic                  imm_en; // b from imm16
        logic [`CR16_XLEN-1:0] imm16;  // imm8 sign extended
    } cr16_ctrl_t;

    // processor status
    typedef struct packed {
        logic c;  // carry / borrow
        logic f;  // signed overflow
        logic l;  // unsigned less, cmp only
        logic n;  // signed less, cmp only
        logic z;  // equal, cmp only
    } cr16_psr_t;

    typedef struct packed {
        logic                  valid;
        logic [`CR16_PC_W-1:0] pc;
        logic                  reg_we;
        logic [3:0]            rdest;
        logic [`CR16_XLEN-1:0] wdata;
        cr16_psr_t             psr;   // flags after the edge
    } cr16_retire_t;

endpackage

// File: logic/fetch_unit.sv
// instruction memory with a load port and the program counter, stepped once per instruction
`timescale 1ns/1ps
`include "cr16_consts.svh"

module fetch_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        imem_we,    // program load, run low
    input  logic [`CR16_PC_W-1:0]       imem_addr,
    input  logic [`CR16_XLEN-1:0]       imem_wdata,
    input  logic                        pc_en,      // one pulse per retire
    output logic [`CR16_PC_W-1:0]       pc,
    output cr16_pkg::cr16_instr_u       instr
);

    localparam int DEPTH = `CR16_IMEM_DEPTH;

    logic [`CR16_XLEN-1:0] imem [DEPTH];  // no reset, contents come from the load port
    logic [`CR16_PC_W-1:0] pc_next;

    // load port
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // wrap at depth, explicit so a non power of two depth still works
    always_comb begin
        if (pc == `CR16_PC_W'(DEPTH - 1)) begin
            pc_next = '0;
        end else begin
            pc_next = pc + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= '0;
        end else if (pc_en) begin
            pc <= pc_next;  // moves at the end of s2
        end
    end

    // async read, ir samples it in s1
    assign instr = imem[pc];

endmodule

// File: logic/register_file.sv
// sixteen general registers, one-hot write on the clock edge and two async read ports
`timescale 1ns/1ps
`include "cr16_consts.svh"

module register_file (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        reg_we,
    input  logic [`CR16_NREGS-1:0]      reg_en,   // one-hot
    input  logic [`CR16_XLEN-1:0]       wdata,    // alu result
    input  logic [3:0]                  raddr_a,  // rdest
    input  logic [3:0]                  raddr_b,  // rsrc
    output logic [`CR16_XLEN-1:0]       rdata_a,
    output logic [`CR16_XLEN-1:0]       rdata_b
);

    localparam int NREGS = `CR16_NREGS;

    logic [`CR16_XLEN-1:0] regs [NREGS];

    // cleared so every program starts from zero
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_we) begin
            for (int i = 0; i < NREGS; i++) begin
                if (reg_en[i]) begin
                    regs[i] <= wdata;
                end
            end
        end
    end

    // no bypass, write lands after the s2 edge
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cr16 testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module cr16_tb -o cr16_sim
./obj_dir/cr16_sim 2>&1 | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// File: sim.f
+incdir+logic
logic/cr16_pkg.sv
logic/fetch_unit.sv
logic/control_and_decoder.sv
logic/register_file.sv
logic/alu.sv
logic/cr16_core.sv
dv/cr16_chk.sv
dv/cr16_monitor.sv
dv/cr16_tb.sv
